// File: src/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

  // data word width
  localparam int xlen = 32;

  typedef logic [xlen-1:0] word_t;
  typedef logic [4:0] reg_idx_t;

  // major opcodes, low two bits always 2'b11 for 32-bit encodings
  typedef enum logic [6:0] {
    op_load    = 7'b00_000_11,
    op_store   = 7'b01_000_11,
    op_branch  = 7'b11_000_11,
    op_jalr    = 7'b11_001_11,
    op_jal     = 7'b11_011_11,
    op_reg_imm = 7'b00_100_11,
    op_reg_reg = 7'b01_100_11,
    op_system  = 7'b11_100_11,
    op_auipc   = 7'b00_101_11,
    op_lui     = 7'b01_101_11
  } opcode_e;

  // branch conditions
  localparam logic [2:0] f3_beq  = 3'b000;
  localparam logic [2:0] f3_bne  = 3'b001;
  localparam logic [2:0] f3_blt  = 3'b100;
  localparam logic [2:0] f3_bge  = 3'b101;
  localparam logic [2:0] f3_bltu = 3'b110;
  localparam logic [2:0] f3_bgeu = 3'b111;

  // load and store widths
  localparam logic [2:0] f3_byte   = 3'b000;
  localparam logic [2:0] f3_half   = 3'b001;
  localparam logic [2:0] f3_word   = 3'b010;
  localparam logic [2:0] f3_byte_u = 3'b100;
  localparam logic [2:0] f3_half_u = 3'b101;

  // add, sub and addi share this one
  localparam logic [2:0] f3_add = 3'b000;

  // funct7 of sub; add uses all zeros
  localparam logic [6:0] funct7_sub = 7'b0100000;

endpackage

`default_nettype wire

// File: src/core_ctrl_pkg.sv
`default_nettype none

package core_ctrl_pkg;

  typedef enum logic {
    alu_add,
    alu_sub
  } alu_op_e;

  // second alu operand
  typedef enum logic {
    src_rs2,
    src_imm
  } alu_src_e;

  // register write-back source
  typedef enum logic [2:0] {
    wb_alu,
    wb_pc4,
    wb_imm,
    wb_pc_imm,
    wb_load
  } wb_sel_e;

  typedef enum logic [2:0] {
    ld_word,
    ld_byte,
    ld_half,
    ld_byte_u,
    ld_half_u
  } load_kind_e;

  // br_always is used for jal
  typedef enum logic [2:0] {
    br_none,
    br_eq,
    br_ne,
    br_lt,
    br_ge,
    br_ltu,
    br_geu,
    br_always
  } br_cond_e;

endpackage

`default_nettype wire

// File: src/reg_file.sv
`default_nettype none

module reg_file (
  input  wire                  clk,
  input  wire                  rst,
  input  wire                  we,
  input  wire rv_isa_pkg::reg_idx_t rd,
  input  wire rv_isa_pkg::word_t    rd_data,
  input  wire rv_isa_pkg::reg_idx_t rs1,
  output rv_isa_pkg::word_t         rs1_data,
  input  wire rv_isa_pkg::reg_idx_t rs2,
  output rv_isa_pkg::word_t         rs2_data
);

  rv_isa_pkg::word_t regs [32];

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && (rd != '0)) begin
      // x0 keeps its reset value
      regs[rd] <= rd_data;
    end
  end

  // combinational read ports, x0 is not special-cased here
  assign rs1_data = regs[rs1];
  assign rs2_data = regs[rs2];

  // x0 reads as zero through reset and every later write
  a_x0_zero: assert property (@(posedge clk) disable iff (rst)
    ((rs1 != '0) || (rs1_data == '0)) && ((rs2 != '0) || (rs2_data == '0)))
    else $error("reg_file: x0 read returned nonzero");

endmodule

`default_nettype wire

// File: src/inst_decoder.sv
`default_nettype none

module inst_decoder (
  input  wire rv_isa_pkg::word_t     inst,
  output rv_isa_pkg::reg_idx_t       rs1,
  output rv_isa_pkg::reg_idx_t       rs2,
  output rv_isa_pkg::reg_idx_t       rd,
  output rv_isa_pkg::word_t          imm,
  output core_ctrl_pkg::alu_op_e     alu_op,
  output core_ctrl_pkg::alu_src_e    alu_src,
  output core_ctrl_pkg::wb_sel_e     wb_sel,
  output logic                       reg_we,
  output logic                       store,
  output core_ctrl_pkg::load_kind_e  load_kind,
  output core_ctrl_pkg::br_cond_e    br_cond,
  output logic                       jalr,
  output logic                       illegal
);

  rv_isa_pkg::opcode_e opcode;
  logic [2:0]          funct3;
  logic [6:0]          funct7;
  rv_isa_pkg::word_t   imm_i;
  rv_isa_pkg::word_t   imm_s;
  rv_isa_pkg::word_t   imm_b;
  rv_isa_pkg::word_t   imm_j;
  rv_isa_pkg::word_t   imm_u;

  assign opcode = rv_isa_pkg::opcode_e'(inst[6:0]);
  assign rd     = inst[11:7];
  assign funct3 = inst[14:12];
  assign rs1    = inst[19:15];
  assign rs2    = inst[24:20];
  assign funct7 = inst[31:25];

  // sign-extended immediates, one per format
  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
  assign imm_u = {inst[31:12], 12'b0};

  always_comb begin
    case (opcode)
      rv_isa_pkg::op_store:                   imm = imm_s;
      rv_isa_pkg::op_branch:                  imm = imm_b;
      rv_isa_pkg::op_jal:                     imm = imm_j;
      rv_isa_pkg::op_lui, rv_isa_pkg::op_auipc: imm = imm_u;
      default:                                imm = imm_i;
    endcase
  end

  always_comb begin
    alu_op    = core_ctrl_pkg::alu_add;
    alu_src   = core_ctrl_pkg::src_rs2;
    wb_sel    = core_ctrl_pkg::wb_alu;
    reg_we    = 1'b0;
    store     = 1'b0;
    load_kind = core_ctrl_pkg::ld_word;
    br_cond   = core_ctrl_pkg::br_none;
    jalr      = 1'b0;
    illegal   = 1'b0;

    case (opcode)
      rv_isa_pkg::op_lui: begin
        reg_we = 1'b1;
        wb_sel = core_ctrl_pkg::wb_imm;
      end
      rv_isa_pkg::op_auipc: begin
        reg_we = 1'b1;
        wb_sel = core_ctrl_pkg::wb_pc_imm;
      end
      rv_isa_pkg::op_jal: begin
        reg_we  = 1'b1;
        wb_sel  = core_ctrl_pkg::wb_pc4;
        br_cond = core_ctrl_pkg::br_always;
      end
      rv_isa_pkg::op_jalr: begin
        reg_we  = 1'b1;
        wb_sel  = core_ctrl_pkg::wb_pc4;
        alu_src = core_ctrl_pkg::src_imm;
        jalr    = 1'b1;
        illegal = (funct3 != '0);
      end
      rv_isa_pkg::op_branch: begin
        case (funct3)
          rv_isa_pkg::f3_beq:  br_cond = core_ctrl_pkg::br_eq;
          rv_isa_pkg::f3_bne:  br_cond = core_ctrl_pkg::br_ne;
          rv_isa_pkg::f3_blt:  br_cond = core_ctrl_pkg::br_lt;
          rv_isa_pkg::f3_bge:  br_cond = core_ctrl_pkg::br_ge;
          rv_isa_pkg::f3_bltu: br_cond = core_ctrl_pkg::br_ltu;
          rv_isa_pkg::f3_bgeu: br_cond = core_ctrl_pkg::br_geu;
          default:             illegal = 1'b1;
        endcase
      end
      rv_isa_pkg::op_load: begin
        reg_we  = 1'b1;
        wb_sel  = core_ctrl_pkg::wb_load;
        alu_src = core_ctrl_pkg::src_imm;
        case (funct3)
          rv_isa_pkg::f3_word:   load_kind = core_ctrl_pkg::ld_word;
          rv_isa_pkg::f3_byte:   load_kind = core_ctrl_pkg::ld_byte;
          rv_isa_pkg::f3_half:   load_kind = core_ctrl_pkg::ld_half;
          rv_isa_pkg::f3_byte_u: load_kind = core_ctrl_pkg::ld_byte_u;
          rv_isa_pkg::f3_half_u: load_kind = core_ctrl_pkg::ld_half_u;
          default:               illegal = 1'b1;
        endcase
      end
      rv_isa_pkg::op_store: begin
        // only sw is supported
        store   = 1'b1;
        alu_src = core_ctrl_pkg::src_imm;
        illegal = (funct3 != rv_isa_pkg::f3_word);
      end
      rv_isa_pkg::op_reg_imm: begin
        reg_we  = 1'b1;
        alu_src = core_ctrl_pkg::src_imm;
        illegal = (funct3 != rv_isa_pkg::f3_add);
      end
      rv_isa_pkg::op_reg_reg: begin
        reg_we = 1'b1;
        if (funct7 == rv_isa_pkg::funct7_sub) begin
          alu_op = core_ctrl_pkg::alu_sub;
        end
        illegal = (funct3 != rv_isa_pkg::f3_add) ||
                  ((funct7 != '0) && (funct7 != rv_isa_pkg::funct7_sub));
      end
      // ecall lands here with every other system encoding
      default: illegal = 1'b1;
    endcase

    // an illegal instruction must not change any state
    if (illegal) begin
      reg_we = 1'b0;
      store  = 1'b0;
    end
  end

  always_comb begin
    a_we_store_excl: assert (!(reg_we && store))
      else $error("inst_decoder: register write and store both set");
  end

endmodule

`default_nettype wire

// File: src/alu_branch.sv
`default_nettype none

module alu_branch (
  input  wire rv_isa_pkg::word_t        a,
  input  wire rv_isa_pkg::word_t        b,
  input  wire core_ctrl_pkg::alu_op_e   alu_op,
  input  wire rv_isa_pkg::word_t        rs1_data,
  input  wire rv_isa_pkg::word_t        rs2_data,
  input  wire core_ctrl_pkg::br_cond_e  br_cond,
  output rv_isa_pkg::word_t             result,
  output logic                          taken
);

  rv_isa_pkg::word_t b_eff;
  logic              carry_in;
  logic              eq;
  logic              lt_s;
  logic              lt_u;

  // single adder, subtract as a + ~b + 1
  assign carry_in = (alu_op == core_ctrl_pkg::alu_sub);
  assign b_eff    = carry_in ? ~b : b;
  assign result   = a + b_eff + rv_isa_pkg::word_t'(carry_in);

  // branch comparator works on the raw register values
  assign eq   = (rs1_data == rs2_data);
  assign lt_s = ($signed(rs1_data) < $signed(rs2_data));
  assign lt_u = (rs1_data < rs2_data);

  always_comb begin
    case (br_cond)
      core_ctrl_pkg::br_eq:     taken = eq;
      core_ctrl_pkg::br_ne:     taken = !eq;
      core_ctrl_pkg::br_lt:     taken = lt_s;
      core_ctrl_pkg::br_ge:     taken = !lt_s;
      core_ctrl_pkg::br_ltu:    taken = lt_u;
      core_ctrl_pkg::br_geu:    taken = !lt_u;
      core_ctrl_pkg::br_always: taken = 1'b1;
      default:                  taken = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

// File: src/rv_core.sv
`default_nettype none

module rv_core #(
  parameter rv_isa_pkg::word_t reset_pc = '0
) (
  input  wire                    clk,
  input  wire                    rst,
  output rv_isa_pkg::word_t      pc,
  input  wire rv_isa_pkg::word_t inst,
  output rv_isa_pkg::word_t      dmem_addr,
  output rv_isa_pkg::word_t      dmem_wdata,
  output logic [3:0]             dmem_we,
  input  wire rv_isa_pkg::word_t dmem_rdata,
  output logic                   halt
);

  rv_isa_pkg::reg_idx_t      rs1;
  rv_isa_pkg::reg_idx_t      rs2;
  rv_isa_pkg::reg_idx_t      rd;
  rv_isa_pkg::word_t         imm;
  core_ctrl_pkg::alu_op_e    alu_op;
  core_ctrl_pkg::alu_src_e   alu_src;
  core_ctrl_pkg::wb_sel_e    wb_sel;
  core_ctrl_pkg::load_kind_e load_kind;
  core_ctrl_pkg::br_cond_e   br_cond;
  logic                      reg_we;
  logic                      store;
  logic                      jalr;
  logic                      illegal;
  rv_isa_pkg::word_t         rs1_data;
  rv_isa_pkg::word_t         rs2_data;
  rv_isa_pkg::word_t         alu_b;
  rv_isa_pkg::word_t         alu_result;
  logic                      taken;
  rv_isa_pkg::word_t         pc_plus4;
  rv_isa_pkg::word_t         pc_imm;
  rv_isa_pkg::word_t         pc_next;
  rv_isa_pkg::word_t         load_val;
  rv_isa_pkg::word_t         rd_data;

  inst_decoder decoder_i (
    .inst      (inst),
    .rs1       (rs1),
    .rs2       (rs2),
    .rd        (rd),
    .imm       (imm),
    .alu_op    (alu_op),
    .alu_src   (alu_src),
    .wb_sel    (wb_sel),
    .reg_we    (reg_we),
    .store     (store),
    .load_kind (load_kind),
    .br_cond   (br_cond),
    .jalr      (jalr),
    .illegal   (illegal)
  );

  reg_file rf_i (
    .clk      (clk),
    .rst      (rst),
    .we       (reg_we && !halt),
    .rd       (rd),
    .rd_data  (rd_data),
    .rs1      (rs1),
    .rs1_data (rs1_data),
    .rs2      (rs2),
    .rs2_data (rs2_data)
  );

  assign alu_b = (alu_src == core_ctrl_pkg::src_imm) ? imm : rs2_data;

  alu_branch alu_i (
    .a        (rs1_data),
    .b        (alu_b),
    .alu_op   (alu_op),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .br_cond  (br_cond),
    .result   (alu_result),
    .taken    (taken)
  );

  assign pc_plus4 = pc + 32'd4;
  assign pc_imm   = pc + imm;

  always_comb begin
    if (jalr) begin
      pc_next = {alu_result[31:1], 1'b0};
    end else if (taken) begin
      pc_next = pc_imm;
    end else begin
      pc_next = pc_plus4;
    end
  end

  // pc stays on the offending instruction once it halts
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      pc   <= reset_pc;
      halt <= 1'b0;
    end else if (!halt) begin
      halt <= illegal;
      if (!illegal) begin
        pc <= pc_next;
      end
    end
  end

  // sub-word loads use the low lanes, address bits 1:0 are ignored
  always_comb begin
    case (load_kind)
      core_ctrl_pkg::ld_byte:   load_val = {{24{dmem_rdata[7]}}, dmem_rdata[7:0]};
      core_ctrl_pkg::ld_half:   load_val = {{16{dmem_rdata[15]}}, dmem_rdata[15:0]};
      core_ctrl_pkg::ld_byte_u: load_val = {24'b0, dmem_rdata[7:0]};
      core_ctrl_pkg::ld_half_u: load_val = {16'b0, dmem_rdata[15:0]};
      default:                  load_val = dmem_rdata;
    endcase
  end

  always_comb begin
    case (wb_sel)
      core_ctrl_pkg::wb_pc4:    rd_data = pc_plus4;
      core_ctrl_pkg::wb_imm:    rd_data = imm;
      core_ctrl_pkg::wb_pc_imm: rd_data = pc_imm;
      core_ctrl_pkg::wb_load:   rd_data = load_val;
      default:                  rd_data = alu_result;
    endcase
  end

  assign dmem_addr  = alu_result;
  assign dmem_wdata = rs2_data;
  assign dmem_we    = (store && !halt) ? 4'b1111 : 4'b0000;

  a_no_store_halted: assert property (@(posedge clk) disable iff (rst)
    halt |-> (dmem_we == '0))
    else $error("rv_core: store issued while halted");

endmodule

`default_nettype wire

// File: tests/rv_model.svh
`ifndef rv_model_svh
`define rv_model_svh

localparam int prog_len = 200;
localparam int dmem_words = 64;
localparam int rand_seed = 92780;
localparam int reset_cycles = 10;
localparam int cycle_limit = reset_cycles + prog_len + 50;
localparam rv_isa_pkg::word_t reset_pc = 32'h0000_0100;

rv_isa_pkg::word_t imem [prog_len];
rv_isa_pkg::word_t m_regs [32];
rv_isa_pkg::word_t m_dmem [dmem_words];
rv_isa_pkg::word_t m_pc;
logic              m_halted;
// store that the current instruction should issue
logic              exp_we;
rv_isa_pkg::word_t exp_addr;
rv_isa_pkg::word_t exp_wdata;
int                gen_idx;

function automatic int rand_range(int lo, int hi);
  return lo + int'($urandom % (hi - lo + 1));
endfunction

function automatic rv_isa_pkg::word_t encode_i(logic [6:0] op, logic [2:0] f3,
                                               logic [4:0] rd, logic [4:0] rs1,
                                               logic [11:0] imm);
  return {imm, rs1, f3, rd, op};
endfunction

function automatic rv_isa_pkg::word_t encode_s(logic [4:0] rs2, logic [4:0] rs1,
                                               logic [11:0] imm);
  return {imm[11:5], rs2, rs1, rv_isa_pkg::f3_word, imm[4:0], rv_isa_pkg::op_store};
endfunction

function automatic rv_isa_pkg::word_t encode_b(logic [2:0] f3, logic [4:0] rs1,
                                               logic [4:0] rs2, logic [12:0] off);
  return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], rv_isa_pkg::op_branch};
endfunction

function automatic rv_isa_pkg::word_t encode_j(logic [4:0] rd, logic [20:0] off);
  return {off[20], off[10:1], off[11], off[19:12], rd, rv_isa_pkg::op_jal};
endfunction

function automatic rv_isa_pkg::word_t encode_u(logic [6:0] op, logic [4:0] rd,
                                               logic [19:0] hi);
  return {hi, rd, op};
endfunction

function automatic rv_isa_pkg::word_t encode_r(logic [6:0] f7, logic [4:0] rs2,
                                               logic [4:0] rs1, logic [4:0] rd);
  return {f7, rs2, rs1, rv_isa_pkg::f3_add, rd, rv_isa_pkg::op_reg_reg};
endfunction

function automatic logic [2:0] branch_f3();
  case (rand_range(0, 5))
    0: return rv_isa_pkg::f3_beq;
    1: return rv_isa_pkg::f3_bne;
    2: return rv_isa_pkg::f3_blt;
    3: return rv_isa_pkg::f3_bge;
    4: return rv_isa_pkg::f3_bltu;
    default: return rv_isa_pkg::f3_bgeu;
  endcase
endfunction

function automatic logic [2:0] load_f3();
  case (rand_range(0, 4))
    0: return rv_isa_pkg::f3_word;
    1: return rv_isa_pkg::f3_byte;
    2: return rv_isa_pkg::f3_half;
    3: return rv_isa_pkg::f3_byte_u;
    default: return rv_isa_pkg::f3_half_u;
  endcase
endfunction

// the last slot is reserved for ecall
function automatic void put_inst(rv_isa_pkg::word_t w);
  if (gen_idx < prog_len - 1) begin
    imem[gen_idx] = w;
    gen_idx++;
  end
endfunction

// forward jump distance in words, never past the ecall
function automatic int fwd_words();
  int n;
  n = rand_range(1, 4);
  if (gen_idx + n > prog_len - 1) begin
    n = prog_len - 1 - gen_idx;
  end
  return n;
endfunction

// x31 holds the data base, max base plus offset stays below 256 bytes
function automatic void store_reg(logic [4:0] r);
  put_inst(encode_i(rv_isa_pkg::op_reg_imm, rv_isa_pkg::f3_add, 5'd31, 5'd0,
                    12'(4 * rand_range(0, 47))));
  put_inst(encode_s(r, 5'd31, 12'(4 * rand_range(0, 15))));
endfunction

task automatic gen_program(input logic inject);
  logic [4:0] rd;
  logic [4:0] rs1;
  logic [4:0] rs2;
  int         kind;
  int         skip;
  gen_idx = 0;
  put_inst(encode_i(rv_isa_pkg::op_reg_imm, rv_isa_pkg::f3_add, 5'd31, 5'd0, 12'h000));
  while (gen_idx < prog_len - 1) begin
    rd   = 5'(rand_range(0, 30));
    rs1  = 5'(rand_range(0, 31));
    rs2  = 5'(rand_range(0, 31));
    kind = rand_range(0, 8);
    skip = fwd_words();
    case (kind)
      0: put_inst(encode_u(rv_isa_pkg::op_lui, rd, 20'($urandom)));
      1: put_inst(encode_u(rv_isa_pkg::op_auipc, rd, 20'($urandom)));
      2: put_inst(encode_i(rv_isa_pkg::op_reg_imm, rv_isa_pkg::f3_add, rd, rs1,
                           12'($urandom)));
      3: put_inst(encode_r(rand_range(0, 1) == 1 ? rv_isa_pkg::funct7_sub : 7'h00,
                           rs2, rs1, rd));
      4: begin
        put_inst(encode_i(rv_isa_pkg::op_reg_imm, rv_isa_pkg::f3_add, 5'd31, 5'd0,
                          12'(4 * rand_range(0, 47))));
        put_inst(encode_i(rv_isa_pkg::op_load, load_f3(), rd, 5'd31,
                          12'(4 * rand_range(0, 15))));
      end
      5: put_inst(encode_b(branch_f3(), rs1, rs2, 13'(4 * skip)));
      6: put_inst(encode_j(rd, 21'(4 * skip)));
      // absolute target through x0, bit 0 sometimes set
      7: put_inst(encode_i(rv_isa_pkg::op_jalr, 3'b000, rd, 5'd0,
                           12'(reset_pc + 32'(4 * (gen_idx + skip)) + 32'(rand_range(0, 1)))));
      default: store_reg(rs2);
    endcase
    if (kind != 5 && kind != 8) begin
      store_reg(rd);
    end
  end
  imem[prog_len - 1] = encode_i(rv_isa_pkg::op_system, 3'b000, 5'd0, 5'd0, 12'h000);
  // mul from the M extension, not supported by the core
  // four slots wide since no forward jump covers more than four words
  if (inject) begin
    for (int i = prog_len / 2; i < prog_len / 2 + 4; i++) begin
      imem[i] = encode_r(7'h01, 5'd1, 5'd2, 5'd3);
    end
  end
endtask

function automatic rv_isa_pkg::word_t fetch(rv_isa_pkg::word_t addr);
  rv_isa_pkg::word_t off;
  off = addr - reset_pc;
  if (off[1:0] == 2'b00 && off < prog_len * 4) begin
    return imem[off[9:2]];
  end
  return 32'h0000_0000;
endfunction

function automatic void write_reg(logic [4:0] rd, rv_isa_pkg::word_t v);
  if (rd != 5'd0) begin
    m_regs[rd] = v;
  end
endfunction

task automatic model_step();
  rv_isa_pkg::word_t w;
  rv_isa_pkg::word_t a;
  rv_isa_pkg::word_t b;
  rv_isa_pkg::word_t imm_i;
  rv_isa_pkg::word_t addr;
  rv_isa_pkg::word_t ld;
  rv_isa_pkg::word_t nxt;
  logic [2:0]        f3;
  logic [4:0]        rd;
  logic              take;
  exp_we = 1'b0;
  if (m_halted) begin
    return;
  end
  w     = fetch(m_pc);
  f3    = w[14:12];
  rd    = w[11:7];
  a     = m_regs[w[19:15]];
  b     = m_regs[w[24:20]];
  imm_i = {{20{w[31]}}, w[31:20]};
  nxt   = m_pc + 32'd4;
  take  = 1'b0;
  case (w[6:0])
    rv_isa_pkg::op_lui: write_reg(rd, {w[31:12], 12'h000});
    rv_isa_pkg::op_auipc: write_reg(rd, m_pc + {w[31:12], 12'h000});
    rv_isa_pkg::op_jal: begin
      write_reg(rd, nxt);
      nxt = m_pc + {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
    end
    rv_isa_pkg::op_jalr: begin
      if (f3 != 3'b000) begin
        m_halted = 1'b1;
      end else begin
        write_reg(rd, nxt);
        nxt = (a + imm_i) & ~32'h1;
      end
    end
    rv_isa_pkg::op_branch: begin
      case (f3)
        rv_isa_pkg::f3_beq:  take = (a == b);
        rv_isa_pkg::f3_bne:  take = (a != b);
        rv_isa_pkg::f3_blt:  take = ($signed(a) < $signed(b));
        rv_isa_pkg::f3_bge:  take = ($signed(a) >= $signed(b));
        rv_isa_pkg::f3_bltu: take = (a < b);
        rv_isa_pkg::f3_bgeu: take = (a >= b);
        default:             m_halted = 1'b1;
      endcase
      if (take) begin
        nxt = m_pc + {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
      end
    end
    rv_isa_pkg::op_load: begin
      addr = a + imm_i;
      ld   = m_dmem[addr[7:2]];
      // sub-word loads always take the low lanes
      case (f3)
        rv_isa_pkg::f3_word:   write_reg(rd, ld);
        rv_isa_pkg::f3_byte:   write_reg(rd, {{24{ld[7]}}, ld[7:0]});
        rv_isa_pkg::f3_half:   write_reg(rd, {{16{ld[15]}}, ld[15:0]});
        rv_isa_pkg::f3_byte_u: write_reg(rd, {24'h0, ld[7:0]});
        rv_isa_pkg::f3_half_u: write_reg(rd, {16'h0, ld[15:0]});
        default:               m_halted = 1'b1;
      endcase
    end
    rv_isa_pkg::op_store: begin
      addr = a + {{20{w[31]}}, w[31:25], w[11:7]};
      if (f3 != rv_isa_pkg::f3_word) begin
        m_halted = 1'b1;
      end else begin
        m_dmem[addr[7:2]] = b;
        exp_we    = 1'b1;
        exp_addr  = addr;
        exp_wdata = b;
      end
    end
    rv_isa_pkg::op_reg_imm: begin
      if (f3 == rv_isa_pkg::f3_add) begin
        write_reg(rd, a + imm_i);
      end else begin
        m_halted = 1'b1;
      end
    end
    rv_isa_pkg::op_reg_reg: begin
      if (f3 == rv_isa_pkg::f3_add && w[31:25] == 7'h00) begin
        write_reg(rd, a + b);
      end else if (f3 == rv_isa_pkg::f3_add && w[31:25] == rv_isa_pkg::funct7_sub) begin
        write_reg(rd, a - b);
      end else begin
        m_halted = 1'b1;
      end
    end
    // ecall and every unknown opcode
    default: m_halted = 1'b1;
  endcase
  if (!m_halted) begin
    m_pc = nxt;
  end
endtask

`endif

// File: tests/tb_rv_core.sv
`default_nettype none

module tb_rv_core;
  timeunit 1ns;
  timeprecision 100ps;

  logic              clk;
  logic              rst;
  rv_isa_pkg::word_t pc;
  rv_isa_pkg::word_t inst;
  rv_isa_pkg::word_t dmem_addr;
  rv_isa_pkg::word_t dmem_wdata;
  logic [3:0]        dmem_we;
  rv_isa_pkg::word_t dmem_rdata;
  logic              halt;

  `include "rv_model.svh"

  rv_isa_pkg::word_t dmem [dmem_words];
  int                errors;
  int                retired;
  string             cur_test;
  logic              st_pending;
  rv_isa_pkg::word_t st_addr;
  rv_isa_pkg::word_t st_data;

  rv_core #(
    .reset_pc (reset_pc)
  ) dut_i (
    .clk        (clk),
    .rst        (rst),
    .pc         (pc),
    .inst       (inst),
    .dmem_addr  (dmem_addr),
    .dmem_wdata (dmem_wdata),
    .dmem_we    (dmem_we),
    .dmem_rdata (dmem_rdata),
    .halt       (halt)
  );

  // both memories answer within the same cycle
  always_comb begin
    inst       = fetch(pc);
    dmem_rdata = dmem[dmem_addr[7:2]];
  end

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic report_mismatch(string what, rv_isa_pkg::word_t exp, rv_isa_pkg::word_t act);
    errors++;
    $display("ERR %s %s: expected %08h, actual %08h", cur_test, what, exp, act);
  endtask

  task automatic run_program(input logic inject, input string name);
    int                cycles;
    int                after_halt;
    rv_isa_pkg::word_t w;
    rv_isa_pkg::word_t exp_be;
    cur_test = name;
    @(posedge clk);
    rst <= 1'b1;
    gen_program(inject);
    for (int i = 0; i < dmem_words; i++) begin
      w = $urandom;
      dmem[i] <= w;
      m_dmem[i] = w;
    end
    for (int i = 0; i < 32; i++) begin
      m_regs[i] = '0;
    end
    m_pc     = reset_pc;
    m_halted = 1'b0;
    repeat (reset_cycles - 1) @(posedge clk);
    @(negedge clk);
    if (pc !== reset_pc) report_mismatch("reset pc", reset_pc, pc);
    if (halt !== 1'b0) report_mismatch("reset halt", 32'h0, 32'(halt));
    if (dmem_we !== 4'h0) report_mismatch("reset dmem_we", 32'h0, 32'(dmem_we));
    @(posedge clk);
    rst <= 1'b0;

    cycles     = reset_cycles;
    after_halt = 0;
    while (after_halt < 4) begin
      @(negedge clk);
      if (pc !== m_pc) report_mismatch("pc", m_pc, pc);
      if (halt !== m_halted) report_mismatch("halt", 32'(m_halted), 32'(halt));
      if (m_halted) begin
        after_halt++;
      end else begin
        retired++;
      end
      model_step();
      exp_be = exp_we ? 32'h0000_000f : 32'h0;
      if (32'(dmem_we) !== exp_be) report_mismatch("dmem_we", exp_be, 32'(dmem_we));
      if (exp_we && dmem_addr !== exp_addr) report_mismatch("sw addr", exp_addr, dmem_addr);
      if (exp_we && dmem_wdata !== exp_wdata) begin
        report_mismatch("sw data", exp_wdata, dmem_wdata);
      end
      // the memory takes whatever the core issues
      st_pending = (dmem_we == 4'hf);
      st_addr    = dmem_addr;
      st_data    = dmem_wdata;
      @(posedge clk);
      if (st_pending) begin
        dmem[st_addr[7:2]] <= st_data;
      end
      cycles++;
      if (cycles > cycle_limit) begin
        $display("timeout in %s: core did not halt within %0d cycles", name, cycle_limit);
        $display("Test FAILED");
        $finish;
      end
    end
  endtask

  initial begin
    rst        = 1'b1;
    errors     = 0;
    retired    = 0;
    st_pending = 1'b0;
    void'($urandom(rand_seed));
    run_program(1'b0, "ecall_run");
    run_program(1'b1, "illegal_run");
    $display("%0d instructions retired, %0d errors", retired, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+tests
src/rv_isa_pkg.sv
src/core_ctrl_pkg.sv
src/reg_file.sv
src/inst_decoder.sv
src/alu_branch.sv
src/rv_core.sv
tests/tb_rv_core.sv

// File: Makefile
SIM := obj_dir/Vtb_rv_core

.PHONY: all run clean

all: run

$(SIM): vlog.f $(shell grep -v '^+' vlog.f) tests/rv_model.svh
	verilator --binary --timing --assert --timescale 1ns/100ps --top-module tb_rv_core -f vlog.f

run: $(SIM)
	$(SIM) > sim.log 2>&1; cat sim.log
	@if grep -q "Test FAILED" sim.log; then exit 1; fi
	@grep -q "Test OK" sim.log

clean:
	rm -rf obj_dir sim.log
